// ==== src/nocSwitch_defs.svh ====
`ifndef NOC_SWITCH_DEFS_SVH
`define NOC_SWITCH_DEFS_SVH

// Input ports in the order Local, North, East, West, South.
`define NOC_PORTS 5

// Flit payload width.
`define NOC_DATA_W 16

// Slot length carried in a header flit.
`define NOC_LEN_W 12

// Entries per input FIFO.
`define NOC_FIFO_DEPTH 4

`endif

// ==== src/nocSwitchPkg.sv ====
`default_nettype none
`include "nocSwitch_defs.svh"

package nocSwitchPkg;

  typedef enum logic [2:0]
  {
    kindHeader = 3'd1,
    kindBody   = 3'd2,
    kindTail   = 3'd3
  } flitKind;

  typedef struct packed
  {
    logic [`NOC_DATA_W-`NOC_LEN_W-1:0] dest;
    logic [`NOC_LEN_W-1:0]             slotLen; // Slot length for the port.
  } headerView;

  // Header flits carry routing and slot info, body and tail carry data.
  typedef union packed
  {
    headerView              header;
    logic [`NOC_DATA_W-1:0] bodyView;
  } flitPayload;

  typedef struct packed
  {
    flitKind    kind;
    flitPayload payload;
  } flit;

  typedef struct packed
  {
    flit                              data;
    logic [$clog2(`NOC_PORTS)-1:0]    srcPort; // Input that sent the flit.
  } outFlit;

endpackage

`default_nettype wire

// ==== src/inputChannel.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module inputChannel
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire nocSwitchPkg::flit inFlit,
  input  wire logic              inValid,
  output logic                   inReady,
  input  wire logic              grant,
  input  wire logic              take,
  output logic                   req,
  output nocSwitchPkg::flit      head,
  output logic                   timesUp
);

  localparam int Depth = `NOC_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam int FillW = $clog2(Depth + 1);

  nocSwitchPkg::flit       mem [Depth];
  logic [PtrW-1:0]         wrPtr;
  logic [PtrW-1:0]         rdPtr;
  logic [FillW-1:0]        fill;
  logic                    push;
  logic                    pop;
  logic                    headIsHeader;
  nocSwitchPkg::headerView headInfo;
  logic [`NOC_LEN_W-1:0]   slotCount;
  logic [`NOC_LEN_W-1:0]   slotLen;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign inReady = (fill != FillW'(Depth));
  assign req     = (fill != '0);
  assign push    = inValid && inReady;
  assign pop     = grant && take && req;

  // An empty FIFO shows a null flit, kind zero.
  assign head = req ? mem[rdPtr] : nocSwitchPkg::flit'('0);

  assign headIsHeader = (mem[rdPtr].kind == nocSwitchPkg::kindHeader);
  assign headInfo     = mem[rdPtr].payload.header;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= nextPtr(wrPtr);
      if (pop)
        rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  // Slot timer, counts pops while this port holds the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      slotCount <= '0;
      slotLen   <= '0;
    end
    else
    begin
      if (!grant)
        slotCount <= '0;
      else if (pop)
        slotCount <= slotCount + 1'b1;

      if (pop && headIsHeader)
        slotLen <= headInfo.slotLen; // New packet sets the slot.
    end
  end

  // Also ends the slot when a shorter length arrives mid-run.
  assign timesUp = (slotCount >= slotLen);

endmodule

`default_nettype wire

// ==== src/switchArbiter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module switchArbiter
(
  input  wire logic [`NOC_PORTS-1:0] req,
  input  wire logic [`NOC_PORTS-1:0] timesUp,
  input  wire logic                  clk,
  input  wire logic                  rst,
  output logic [`NOC_PORTS-1:0]      grant
);

  localparam int Ports = `NOC_PORTS;

  // One-hot states, bit 0 is Idle and bit p+1 grants port p.
  localparam logic [Ports:0] StIdle  = {{Ports{1'b0}}, 1'b1};
  localparam logic [Ports:0] StLocal = StIdle << 1;
  localparam logic [Ports:0] StNorth = StIdle << 2;
  localparam logic [Ports:0] StEast  = StIdle << 3;
  localparam logic [Ports:0] StWest  = StIdle << 4;
  localparam logic [Ports:0] StSouth = StIdle << 5;

  logic [Ports:0] state;
  logic [Ports:0] stateNext;

  // First requester from port first onward, over span ports.
  function automatic logic [Ports:0] pickFrom
  (
    input logic [Ports-1:0] r,
    input int               first,
    input int               span
  );
    logic [Ports:0] pick;
    int             idx;
    pick = StIdle;
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % Ports;
      if (r[idx])
      begin
        pick           = '0;
        pick[idx + 1]  = 1'b1; // Lowest offset wins.
      end
    end
    return pick;
  endfunction

  // Keep the grant while the port requests and its slot runs, else rotate.
  function automatic logic [Ports:0] stayOrRotate
  (
    input logic [Ports-1:0] r,
    input logic [Ports-1:0] tu,
    input int               p
  );
    logic [Ports:0] own;
    own        = '0;
    own[p + 1] = 1'b1;
    if (r[p] && !tu[p])
      return own;
    return pickFrom(r, p + 1, Ports - 1); // The port itself is skipped.
  endfunction

  always_comb
  begin
    case (state)
      StIdle:  stateNext = pickFrom(req, 0, Ports);
      StLocal: stateNext = stayOrRotate(req, timesUp, 0);
      StNorth: stateNext = stayOrRotate(req, timesUp, 1);
      StEast:  stateNext = stayOrRotate(req, timesUp, 2);
      StWest:  stateNext = stayOrRotate(req, timesUp, 3);
      StSouth: stateNext = stayOrRotate(req, timesUp, 4);
      default: stateNext = StIdle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= StIdle;
    else
      state <= stateNext;
  end

  assign grant = state[Ports:1];

endmodule

`default_nettype wire

// ==== src/outputStage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module outputStage
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic [`NOC_PORTS-1:0] grant,
  input  wire nocSwitchPkg::flit     heads [`NOC_PORTS],
  output logic                       take,
  output nocSwitchPkg::outFlit       outData,
  output logic                       outValid,
  input  wire logic                  outReady
);

  localparam int Ports = `NOC_PORTS;
  localparam int SrcW  = $clog2(`NOC_PORTS);

  nocSwitchPkg::flit selFlit;
  logic [SrcW-1:0]   selSrc;
  logic              selLive;
  logic              load;

  // One-hot mux and source encoder.
  always_comb
  begin
    selFlit = '0;
    selSrc  = '0;
    for (int p = 0; p < Ports; p++)
    begin
      if (grant[p])
      begin
        selFlit = heads[p];
        selSrc  = SrcW'(p);
      end
    end
  end

  // A null head means the granted FIFO just ran dry.
  assign selLive = selFlit.kind inside {nocSwitchPkg::kindHeader,
                                        nocSwitchPkg::kindBody,
                                        nocSwitchPkg::kindTail};

  assign take = !outValid || outReady;
  assign load = take && (|grant) && selLive;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (load)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0; // Drained with nothing behind it.
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outData.data    <= selFlit;
      outData.srcPort <= selSrc;
    end
  end

endmodule

`default_nettype wire

// ==== src/nocSwitch.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module nocSwitch
(
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire nocSwitchPkg::flit     inFlit [`NOC_PORTS],
  input  wire logic [`NOC_PORTS-1:0] inValid,
  output wire logic [`NOC_PORTS-1:0] inReady,
  output nocSwitchPkg::outFlit       outData,
  output logic                       outValid,
  input  wire logic                  outReady
);

  wire logic [`NOC_PORTS-1:0] req;
  wire logic [`NOC_PORTS-1:0] timesUp;
  wire nocSwitchPkg::flit     head [`NOC_PORTS];
  logic [`NOC_PORTS-1:0]      grant;
  logic                       take;

  // Local, North, East, West, South.
  for (genvar i = 0; i < `NOC_PORTS; i++)
  begin : gChan
    inputChannel uChan
    (
      .clk     (clk),
      .rst     (rst),
      .inFlit  (inFlit[i]),
      .inValid (inValid[i]),
      .inReady (inReady[i]),
      .grant   (grant[i]),
      .take    (take),
      .req     (req[i]),
      .head    (head[i]),
      .timesUp (timesUp[i])
    );
  end

  switchArbiter uArb
  (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .timesUp (timesUp),
    .grant   (grant)
  );

  outputStage uOut
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .heads    (head),
    .take     (take),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

endmodule

`default_nettype wire

// ==== verification/nocSwitch_sva.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module nocSwitchSva
(
  input wire logic                  clk,
  input wire logic                  rst,
  input wire logic [`NOC_PORTS-1:0] grant,
  input wire nocSwitchPkg::outFlit  outData,
  input wire logic                  outValid,
  input wire logic                  outReady
);

  // Only one input may own the output at a time.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is neither one-hot nor zero");

  stallHold: assert property
  (
    @(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outData))
  )
    else $error("output flit changed while the output was stalled");

  resetIdle: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high right after reset");

endmodule

`default_nettype wire

// ==== verification/nocSwitchTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "nocSwitch_defs.svh"

module nocSwitchTb;

  localparam int RandPkts       = 3;
  localparam int SatPkts        = 4;
  localparam int WatchdogCycles = `NOC_PORTS * (RandPkts + SatPkts) * 200 + 500;

  logic                  clk;
  logic                  rst;
  nocSwitchPkg::flit     inFlit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] inValid;
  logic [`NOC_PORTS-1:0] inReady;
  nocSwitchPkg::outFlit  outData;
  logic                  outValid;
  logic                  outReady;

  logic [15:0]           lfsrState;
  nocSwitchPkg::flit     srcQ [`NOC_PORTS][$];  // Flits not yet offered or accepted.
  nocSwitchPkg::flit     portQ [`NOC_PORTS][$]; // Accepted, not yet seen at the output.
  int                    storedLen [`NOC_PORTS];
  int                    flitsIn;
  int                    flitsOut;
  int                    runPort;
  int                    runLen;
  int                    runCap;
  logic                  slotCheck;
  logic                  stallSeen;
  nocSwitchPkg::outFlit  heldData;

  nocSwitch DUT
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .inReady  (inReady),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

  bind nocSwitch nocSwitchSva uSva
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compareValues(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("FAIL %0t ns: %s (got 0x%0h, expected 0x%0h)", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Mismatch.");
    end
  endtask

  // Taps 16, 14, 13, 11.
  function automatic logic nextBit();
    logic fb;
    fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
      v = {v[14:0], nextBit()};
    return v;
  endfunction

  task automatic queuePacket(input int port);
    nocSwitchPkg::flit f;
    int                len;
    int                bodies;
    len                      = 1 + int'(randBits(3)) % 6;
    f.kind                   = nocSwitchPkg::kindHeader;
    f.payload.header.dest    = 4'(randBits(4));
    f.payload.header.slotLen = 12'(len);
    srcQ[port].push_back(f);
    bodies = int'(randBits(2));
    for (int k = 0; k <= bodies; k++)
    begin
      f.kind             = (k == bodies) ? nocSwitchPkg::kindTail : nocSwitchPkg::kindBody;
      f.payload.bodyView = randBits(16);
      srcQ[port].push_back(f);
    end
  endtask

  // Valid stays up until the flit is taken.
  task automatic driveCycle(input logic saturate);
    logic accepted;
    @(posedge clk);
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      accepted = inValid[i] && inReady[i];
      if (accepted)
        void'(srcQ[i].pop_front());
      if (!inValid[i] || accepted)
      begin
        if (srcQ[i].size() > 0 && (saturate || nextBit()))
        begin
          inFlit[i]  <= srcQ[i][0];
          inValid[i] <= 1'b1;
        end
        else
          inValid[i] <= 1'b0;
      end
      if (saturate && srcQ[i].size() == 0)
        slotCheck <= 1'b0; // One port has stopped sending.
    end
    outReady <= saturate ? 1'b1 : (randBits(2) != 16'd0);
  endtask

  function automatic logic allDrained();
    logic idle;
    idle = (inValid == '0) && !outValid;
    for (int i = 0; i < `NOC_PORTS; i++)
      idle = idle && (srcQ[i].size() == 0) && (portQ[i].size() == 0);
    return idle;
  endfunction

  // Reference model, oldest flit of the port and the slot it sets.
  function automatic nocSwitchPkg::flit predictFlit(input int port);
    nocSwitchPkg::flit f;
    f = portQ[port].pop_front();
    if (f.kind == nocSwitchPkg::kindHeader)
      storedLen[port] = int'(f.payload.header.slotLen);
    return f;
  endfunction

  function automatic int runLimit(input int port);
    return storedLen[port] + 1;
  endfunction

  task automatic scoreOutput();
    int                src;
    nocSwitchPkg::flit exp;
    src = int'(outData.srcPort);
    compareValues(32'(src < `NOC_PORTS), 1, "source port index in range");
    compareValues(32'(portQ[src].size() > 0), 1, "output flit has an accepted flit behind it");
    if (slotCheck)
    begin
      if (src != runPort)
      begin
        runPort = src;
        runLen  = 0;
        runCap  = runLimit(src);
      end
      runLen++;
      compareValues(32'(runLen <= runCap), 1, "run of one port within its slot");
    end
    else
      runPort = -1;
    exp = predictFlit(src);
    if (runLimit(src) > runCap)
      runCap = runLimit(src);
    compareValues(32'(outData.data.kind), 32'(exp.kind), "flit kind");
    if (exp.kind == nocSwitchPkg::kindHeader)
    begin
      compareValues(32'(outData.data.payload.header.dest), 32'(exp.payload.header.dest),
                    "header destination");
      compareValues(32'(outData.data.payload.header.slotLen),
                    32'(exp.payload.header.slotLen), "header slot length");
    end
    else
      compareValues(32'(outData.data.payload.bodyView), 32'(exp.payload.bodyView), "data word");
    flitsOut++;
  endtask

  always @(posedge clk)
  begin
    if (!rst)
    begin
      for (int i = 0; i < `NOC_PORTS; i++)
      begin
        if (inValid[i] && inReady[i])
        begin
          portQ[i].push_back(inFlit[i]);
          flitsIn++;
        end
      end
      if (stallSeen)
      begin
        compareValues(32'(outValid), 1, "outValid held under stall");
        compareValues(32'(outData), 32'(heldData), "outData held under stall");
      end
      if (outValid && outReady)
        scoreOutput();
      stallSeen = outValid && !outReady;
      heldData  = outData;
    end
  end

  initial
  begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles without the switch draining", WatchdogCycles);
    $display("Something failed");
    $fatal(1, "Timeout.");
  end

  initial
  begin
    rst       = 1'b1;
    inValid   = '0;
    outReady  = 1'b0;
    lfsrState = 16'd98;
    slotCheck = 1'b0;
    stallSeen = 1'b0;
    flitsIn   = 0;
    flitsOut  = 0;
    runPort   = -1;
    runLen    = 0;
    runCap    = 0;
    for (int i = 0; i < `NOC_PORTS; i++)
    begin
      inFlit[i]    = '0;
      storedLen[i] = 0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    compareValues(32'(outValid), 0, "outValid after reset");
    compareValues(32'(inReady), 32'((1 << `NOC_PORTS) - 1), "inReady after reset");
    for (int p = 0; p < `NOC_PORTS; p++)
      for (int k = 0; k < RandPkts; k++)
        queuePacket(p);
    do
      driveCycle(1'b0);
    while (!allDrained());
    for (int p = 0; p < `NOC_PORTS; p++)
      for (int k = 0; k < SatPkts; k++)
        queuePacket(p);
    slotCheck <= 1'b1; // All five inputs stay busy from here.
    do
      driveCycle(1'b1);
    while (!allDrained());
    if (flitsOut == flitsIn && allDrained())
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("FAIL %0t ns: %0d flits out, %0d accepted", $time, flitsOut, flitsIn);
      $display("Something failed");
      $fatal(1, "Flit count mismatch.");
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+src
src/nocSwitchPkg.sv
src/inputChannel.sv
src/switchArbiter.sv
src/outputStage.sv
src/nocSwitch.sv
verification/nocSwitch_sva.sv
verification/nocSwitchTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status follows the simulation.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f tb.f --top-module nocSwitchTb &&
./obj_dir/VnocSwitchTb ||
{
  echo "Simulation build or run failed"
  exit 1
}
